// ==== vlog.f ====
+incdir+verilog
+incdir+tb
verilog/fxp_pkg.sv
verilog/div_regs_pkg.sv
verilog/fxp_zoom.sv
verilog/fxp_div_pipe.sv
verilog/div_regs.sv
verilog/fxp_div_top.sv
tb/tb_fxp_div.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP := tb_fxp_div
RTL_TOP := fxp_div_top
FILELIST := vlog.f
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_fxp_div_model.svh ====
// lfsr state, seeded at the start of the run
logic [31:0] lfsr_state;

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h8020_0003;
	end
	return s >> 1;
endfunction

// n random bits, one lfsr step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
	return r;
endfunction

// mostly full range, now and then the most negative value
function automatic logic [15:0] random_dividend();
	logic [31:0] r;
	r = rand_bits(3);
	if (r == 0) begin
		return 16'h8000;
	end
	r = rand_bits(16);
	return r[15:0];
endfunction

// zero, most negative, below one (large quotients) or full range
function automatic logic [15:0] random_divisor();
	logic [31:0] sel;
	logic [31:0] r;
	sel = rand_bits(3);
	r = rand_bits(16);
	case (sel)
		0: return 16'h0000;
		1: return 16'h8000;
		2, 3: return {{8{r[7]}}, r[7:0]};
		default: return r[15:0];
	endcase
endfunction

// -32768 stays exact as an unsigned 16-bit magnitude
function automatic logic [15:0] magnitude(input logic [15:0] w);
	if (w[15]) begin
		return 16'h0000 - w;
	end
	return w;
endfunction

// expected {out, overflow} for one operand pair
function automatic logic [16:0] model_div(input logic [15:0] a, input logic [15:0] b,
		input logic rnd);
	logic [31:0] num;
	logic [31:0] den;
	logic [31:0] acc;
	logic [31:0] step;
	logic [15:0] q;
	logic [15:0] res;
	logic ovf;
	// magnitudes as 16.16 words
	num = {8'd0, magnitude(a), 8'd0};
	den = {8'd0, magnitude(b), 8'd0};
	acc = '0;
	q = '0;
	// quotient bit k weighs 2^(k-8), strict compare
	for (int k = 15; k >= 0; k--) begin
		step = (k >= 8) ? (den << (k - 8)) : (den >> (8 - k));
		if (acc + step < num) begin
			acc = acc + step;
			q[k] = 1'b1;
		end
	end
	// one more LSB when that lands closer to the dividend
	if (rnd && q != 16'hffff && (acc + (den >> 8) - num) < (num - acc)) begin
		q = q + 16'd1;
	end
	ovf = 1'b0;
	if (!(a[15] ^ b[15])) begin
		res = q;
		if (q > 16'h7fff) begin
			res = 16'h7fff;
			ovf = 1'b1;
		end
	end else begin
		res = 16'h0000 - q;
		if (q > 16'h8000) begin
			res = 16'h8000;
			ovf = 1'b1;
		end
	end
	return {res, ovf};
endfunction

// ==== tb/tb_fxp_div.sv ====
`timescale 1ns/1ps
`include "fxp_config.svh"

module tb_fxp_div
	import fxp_pkg::*;
	import div_regs_pkg::*;
();

	// ready shows up this many falling edges after valid was seen
	localparam int LATENCY = `FXP_WOI + `FXP_WOF + 3;

	typedef struct {
		int due;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] q;
		logic ovf;
	} item_t;

	logic clk;
	logic rstn;
	logic valid;
	dividend_t dividend;
	divisor_t divisor;
	logic ready;
	quotient_t out;
	logic overflow;
	logic reg_wr;
	logic reg_rd;
	reg_addr_t reg_addr;
	reg_word_t reg_wdata;
	reg_word_t reg_rdata;

	item_t sb_q[$];
	int cyc;
	logic round_shadow;
	int issued_cnt;
	int ovf_cnt;
	int ready_run;
	int longest_run;
	int value_errors;
	int timing_errors;
	int reg_errors;
	int timeout_errors;

	`include "tb_fxp_div_model.svh"

	fxp_div_top i_dut (
		.clk(clk),
		.rstn(rstn),
		.valid(valid),
		.dividend(dividend),
		.divisor(divisor),
		.ready(ready),
		.out(out),
		.overflow(overflow),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20;
			clk = ~clk;
		end
	end

	// ----------------------------------------
	// scoreboard, sampled on the falling edge
	// ----------------------------------------

	always @(negedge clk) begin : monitor
		item_t it;
		logic [16:0] e;
		cyc = cyc + 1;
		if (rstn) begin
			if (valid) begin
				e = model_div(dividend, divisor, round_shadow);
				it.q = e[16:1];
				it.ovf = e[0];
				it.due = cyc + LATENCY;
				it.a = dividend;
				it.b = divisor;
				sb_q.push_back(it);
				issued_cnt++;
				if (it.ovf) begin
					ovf_cnt++;
				end
			end
			if (ready) begin
				ready_run++;
				if (ready_run > longest_run) begin
					longest_run = ready_run;
				end
				if (sb_q.size() == 0) begin
					timing_errors++;
					$display("[ERROR] %0t: ready with no item in flight", $time);
				end else begin
					it = sb_q.pop_front();
					if (it.due != cyc) begin
						timing_errors++;
						$display("[ERROR] %0t: ready at cycle %0d, expected cycle %0d",
							$time, cyc, it.due);
					end
					if (out !== it.q || overflow !== it.ovf) begin
						value_errors++;
						$display("[ERROR] %0t: %h / %h gave %h ovf %b, expected %h ovf %b",
							$time, it.a, it.b, out, overflow, it.q, it.ovf);
					end
				end
			end else begin
				ready_run = 0;
				if (sb_q.size() != 0 && sb_q[0].due <= cyc) begin
					it = sb_q.pop_front();
					timing_errors++;
					$display("ready never came for %h / %h, due at cycle %0d", it.a, it.b, it.due);
				end
			end
			// new round bit applies from the next valid
			if (reg_wr && reg_addr == ADDR_CTRL) begin
				round_shadow = reg_wdata[CTRL_ROUND_BIT];
			end
		end
	end

	// ----------------------------------------
	// stimulus tasks
	// ----------------------------------------

	task automatic drive_cycle(input logic v, input logic [15:0] a, input logic [15:0] b,
			input logic wr, input logic [15:0] wdata);
		@(posedge clk);
		valid <= v;
		dividend <= a;
		divisor <= b;
		reg_wr <= wr;
		reg_rd <= 1'b0;
		reg_addr <= ADDR_CTRL;
		reg_wdata <= wdata;
	endtask

	task automatic write_ctrl(input logic [15:0] data);
		drive_cycle(1'b0, 16'h0000, 16'h0000, 1'b1, data);
		drive_cycle(1'b0, 16'h0000, 16'h0000, 1'b0, 16'h0000);
	endtask

	task automatic check_reg(input reg_addr_t addr, input logic [15:0] expected);
		@(posedge clk);
		valid <= 1'b0;
		reg_wr <= 1'b0;
		reg_rd <= 1'b1;
		reg_addr <= addr;
		@(negedge clk);
		if (reg_rdata !== expected) begin
			reg_errors++;
			$display("[ERROR] %0t: register %0d read %h, expected %h",
				$time, addr, reg_rdata, expected);
		end
	endtask

	// 75% valid density, optional random rewrite of the round bit
	task automatic random_slot(input logic toggle_round);
		logic [31:0] v;
		logic [31:0] w;
		logic [31:0] rbit;
		logic [15:0] a;
		logic [15:0] b;
		v = rand_bits(2);
		a = random_dividend();
		b = random_divisor();
		w = rand_bits(3);
		rbit = rand_bits(1);
		drive_cycle(v != 0, a, b, toggle_round && w == 0, {15'd0, rbit[0]});
	endtask

	task automatic drain();
		int t;
		t = 0;
		drive_cycle(1'b0, 16'h0000, 16'h0000, 1'b0, 16'h0000);
		while (sb_q.size() != 0 && t < 4 * LATENCY + 20) begin
			@(negedge clk);
			t++;
		end
		if (sb_q.size() != 0) begin
			timeout_errors++;
			$display("timeout: %0d results never arrived on ready", sb_q.size());
			sb_q.delete();
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin : main
		logic [31:0] sat_ops [0:7];
		logic [31:0] r;
		sat_ops = '{32'h7fff_0001, 32'h8000_0001, 32'h8000_0100, 32'h0100_0000,
			32'hff00_0000, 32'h8000_ff00, 32'h8000_8000, 32'h4000_0080};
		lfsr_state = 32'd82;
		cyc = 0;
		round_shadow = 1'b0;
		issued_cnt = 0;
		ovf_cnt = 0;
		ready_run = 0;
		longest_run = 0;
		value_errors = 0;
		timing_errors = 0;
		reg_errors = 0;
		timeout_errors = 0;
		rstn = 1'b0;
		valid = 1'b0;
		dividend = '0;
		divisor = '0;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		repeat (5) begin
			@(posedge clk);
		end
		rstn <= 1'b1;

		// idle outputs and cleared registers
		@(negedge clk);
		if (ready !== 1'b0 || overflow !== 1'b0 || out !== 16'h0000) begin
			reg_errors++;
			$display("[ERROR] %0t: outputs not idle after reset", $time);
		end
		check_reg(ADDR_CTRL, 16'h0000);
		check_reg(ADDR_RESULTS, 16'h0000);
		check_reg(ADDR_OVERFLOWS, 16'h0000);
		check_reg(2'd3, 16'h0000);

		// random quotients with rounding off
		repeat (200) begin
			random_slot(1'b0);
		end
		drain();

		// round bit rewritten inside a burst
		repeat (150) begin
			random_slot(1'b1);
		end
		drain();

		// saturation corners in both rounding modes
		for (int m = 0; m < 2; m++) begin
			write_ctrl(16'(m));
			foreach (sat_ops[i]) begin
				drive_cycle(1'b1, sat_ops[i][31:16], sat_ops[i][15:0], 1'b0, 16'h0000);
			end
		end
		drain();

		// 30 back to back, then sparse
		write_ctrl(16'h0000);
		longest_run = 0;
		repeat (30) begin
			drive_cycle(1'b1, random_dividend(), random_divisor(), 1'b0, 16'h0000);
		end
		repeat (60) begin
			r = rand_bits(3);
			drive_cycle(r == 0, random_dividend(), random_divisor(), 1'b0, 16'h0000);
		end
		drain();
		if (longest_run < 30) begin
			timing_errors++;
			$display("[ERROR] %0t: longest ready burst %0d, expected 30", $time, longest_run);
		end

		// counters, stored control bits, clear pulse
		check_reg(ADDR_RESULTS, 16'(issued_cnt));
		check_reg(ADDR_OVERFLOWS, 16'(ovf_cnt));
		write_ctrl(16'hfffd);
		check_reg(ADDR_CTRL, 16'h0001);
		check_reg(ADDR_RESULTS, 16'(issued_cnt));
		write_ctrl(16'h0003);
		issued_cnt = 0;
		ovf_cnt = 0;
		check_reg(ADDR_CTRL, 16'h0001);
		check_reg(ADDR_RESULTS, 16'h0000);
		check_reg(ADDR_OVERFLOWS, 16'h0000);
		write_ctrl(16'h0000);
		check_reg(ADDR_CTRL, 16'h0000);

		$display("errors: value %0d, timing %0d, register %0d, timeout %0d",
			value_errors, timing_errors, reg_errors, timeout_errors);
		if (value_errors + timing_errors + reg_errors + timeout_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verilog/fxp_div_top.sv ====
`timescale 1ns/1ps

module fxp_div_top
	import fxp_pkg::*;
	import div_regs_pkg::*;
(
	input logic clk,
	input logic rstn,
	// operand path
	input logic valid,
	input dividend_t dividend,
	input divisor_t divisor,
	output logic ready,
	output quotient_t out,
	output logic overflow,
	// register access
	input logic reg_wr,
	input logic reg_rd,
	input reg_addr_t reg_addr,
	input reg_word_t reg_wdata,
	output reg_word_t reg_rdata
);

	// round option from the control register
	logic round_en;

	div_regs i_regs (
		.clk(clk),
		.rstn(rstn),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.ready(ready),
		.overflow(overflow),
		.round_en(round_en)
	);

	fxp_div_pipe i_div (
		.clk(clk),
		.rstn(rstn),
		.valid(valid),
		.round_en(round_en),
		.dividend(dividend),
		.divisor(divisor),
		.ready(ready),
		.out(out),
		.overflow(overflow)
	);

endmodule

// ==== verilog/div_regs.sv ====
`timescale 1ns/1ps
`include "fxp_config.svh"

module div_regs
	import div_regs_pkg::*;
(
	input logic clk,
	input logic rstn,
	input logic reg_wr,
	input logic reg_rd,
	input reg_addr_t reg_addr,
	input reg_word_t reg_wdata,
	output reg_word_t reg_rdata,
	input logic ready,
	input logic overflow,
	output logic round_en
);

	logic [`DIV_CNT_W-1:0] result_cnt;
	logic [`DIV_CNT_W-1:0] overflow_cnt;
	logic ctrl_wr;
	logic clear;

	assign ctrl_wr = reg_wr && (reg_addr == ADDR_CTRL);
	// clear bit is a pulse, never stored
	assign clear = ctrl_wr && reg_wdata[CTRL_CLEAR_BIT];

	// ----------------------------------------
	// control register
	// ----------------------------------------

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			round_en <= 1'b0;
		end else if (ctrl_wr) begin
			round_en <= reg_wdata[CTRL_ROUND_BIT];
		end
	end

	// ----------------------------------------
	// result and overflow counters
	// ----------------------------------------

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			result_cnt <= '0;
			overflow_cnt <= '0;
		end else if (clear) begin
			// clear wins over a result in the same cycle
			result_cnt <= '0;
			overflow_cnt <= '0;
		end else if (ready) begin
			result_cnt <= result_cnt + 1'b1;
			if (overflow) begin
				overflow_cnt <= overflow_cnt + 1'b1;
			end
		end
	end

	// ----------------------------------------
	// read mux
	// ----------------------------------------

	always_comb begin
		reg_rdata = '0;
		if (reg_rd) begin
			case (reg_addr)
				ADDR_CTRL: begin
					reg_rdata[CTRL_ROUND_BIT] = round_en;
				end
				ADDR_RESULTS: begin
					reg_rdata = reg_word_t'(result_cnt);
				end
				ADDR_OVERFLOWS: begin
					reg_rdata = reg_word_t'(overflow_cnt);
				end
				// unmapped addresses read zero
				default: begin
					reg_rdata = '0;
				end
			endcase
		end
	end

endmodule

// ==== verilog/fxp_div_pipe.sv ====
`timescale 1ns/1ps
`include "fxp_config.svh"

module fxp_div_pipe
	import fxp_pkg::*;
(
	input logic clk,
	input logic rstn,
	input logic valid,
	input logic round_en,
	input dividend_t dividend,
	input divisor_t divisor,
	output logic ready,
	output quotient_t out,
	output logic overflow
);

	localparam int WA = $bits(dividend_t);
	localparam int WB = $bits(divisor_t);
	localparam int WQ = $bits(quotient_t);
	localparam int WOI = `FXP_WOI;
	localparam int WOF = `FXP_WOF;
	// one quotient bit per stage
	localparam int NS = WQ;
	// ready is one more flop after the shift register
	localparam int VLEN = `FXP_DIV_LATENCY - 1;

	localparam quotient_t MAX_POS = {1'b0, {(WQ-1){1'b1}}};
	localparam quotient_t MAX_NEG = {1'b1, {(WQ-1){1'b0}}};

	logic [WA-1:0] dividend_mag;
	logic [WB-1:0] divisor_mag;
	work_t divd;
	work_t divr;

	// per-stage payload, index 0 is the sign/magnitude stage
	work_t divd_q [0:NS];
	work_t divr_q [0:NS];
	logic sign_q [0:NS];
	logic rnd_q [0:NS];
	work_t acc_q [1:NS];
	logic [WQ-1:0] res_q [1:NS];

	logic [WQ-1:0] rounded;
	logic rsign;
	work_t rem_over;
	work_t rem_under;

	logic [VLEN-1:0] valid_sr;

	// ----------------------------------------
	// valid tracking
	// ----------------------------------------

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			valid_sr <= '0;
			ready <= 1'b0;
		end else begin
			valid_sr <= {valid_sr[VLEN-2:0], valid};
			ready <= valid_sr[VLEN-1];
		end
	end

	// ----------------------------------------
	// stage 1: magnitudes and sign
	// ----------------------------------------

	// most negative input maps to its unsigned magnitude, still exact
	assign dividend_mag = dividend[WA-1] ? WA'(-dividend) : WA'(dividend);
	assign divisor_mag = divisor[WB-1] ? WB'(-divisor) : WB'(divisor);

	fxp_zoom #(
		.WII(`FXP_WIIA),
		.WIF(`FXP_WIFA),
		.WOI(`FXP_WRI),
		.WOF(`FXP_WRF)
	) i_dividend_zoom (
		.in(dividend_mag),
		.out(divd)
	);

	fxp_zoom #(
		.WII(`FXP_WIIB),
		.WIF(`FXP_WIFB),
		.WOI(`FXP_WRI),
		.WOF(`FXP_WRF)
	) i_divisor_zoom (
		.in(divisor_mag),
		.out(divr)
	);

	always_ff @(posedge clk) begin
		divd_q[0] <= divd;
		divr_q[0] <= divr;
		sign_q[0] <= dividend[WA-1] ^ divisor[WB-1];
		// round option travels with its operand pair
		rnd_q[0] <= round_en;
	end

	// ----------------------------------------
	// quotient stages, MSB first
	// ----------------------------------------

	for (genvar i = 0; i < NS; i++) begin : g_stage
		work_t acc_in;
		logic [WQ-1:0] res_in;
		work_t shifted;
		work_t trial;

		if (i == 0) begin : g_first
			assign acc_in = '0;
			assign res_in = '0;
		end else begin : g_next
			assign acc_in = acc_q[i];
			assign res_in = res_q[i];
		end

		// divisor weighted by this quotient bit
		if (i < WOI) begin : g_int_bit
			assign shifted = divr_q[i] << (WOI - 1 - i);
		end else begin : g_frac_bit
			assign shifted = divr_q[i] >> (1 + i - WOI);
		end

		assign trial = acc_in + shifted;

		always_ff @(posedge clk) begin
			divd_q[i+1] <= divd_q[i];
			divr_q[i+1] <= divr_q[i];
			sign_q[i+1] <= sign_q[i];
			rnd_q[i+1] <= rnd_q[i];
			// strict compare, so exact multiples leave the bit clear
			if (trial < divd_q[i]) begin
				acc_q[i+1] <= trial;
				res_q[i+1] <= res_in | (WQ'(1) << (WQ - 1 - i));
			end else begin
				acc_q[i+1] <= acc_in;
				res_q[i+1] <= res_in;
			end
		end
	end

	// ----------------------------------------
	// rounding stage
	// ----------------------------------------

	// distance above and below the dividend for the next LSB step
	assign rem_over = acc_q[NS] + (divr_q[NS] >> WOF) - divd_q[NS];
	assign rem_under = divd_q[NS] - acc_q[NS];

	always_ff @(posedge clk) begin
		// all ones cannot take another LSB
		if (rnd_q[NS] && !(&res_q[NS]) && (rem_over < rem_under)) begin
			rounded <= res_q[NS] + WQ'(1);
		end else begin
			rounded <= res_q[NS];
		end
		rsign <= sign_q[NS];
	end

	// ----------------------------------------
	// sign and saturation stage
	// ----------------------------------------

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			out <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= 1'b0;
			if (rsign) begin
				if (rounded[WQ-1]) begin
					// exactly -128.0 still fits
					overflow <= |rounded[WQ-2:0];
					out <= MAX_NEG;
				end else begin
					out <= quotient_t'(~rounded + WQ'(1));
				end
			end else if (rounded[WQ-1]) begin
				overflow <= 1'b1;
				out <= MAX_POS;
			end else begin
				out <= quotient_t'(rounded);
			end
		end
	end

endmodule

// ==== verilog/fxp_zoom.sv ====
`timescale 1ns/1ps

module fxp_zoom #(
	parameter int WII = 8,
	parameter int WIF = 8,
	parameter int WOI = 16,
	parameter int WOF = 16
) (
	input logic [WII+WIF-1:0] in,
	output logic [WOI+WOF-1:0] out
);

	localparam int WIN = WII + WIF;

	// integer and fraction fields after resizing
	logic [WOI-1:0] int_out;
	logic [WOF-1:0] frac_out;

	// ----------------------------------------
	// fraction part
	// ----------------------------------------

	if (WOF >= WIF) begin : g_frac_widen
		// pad zeros below the input LSB
		assign frac_out = WOF'(in[WIF-1:0]) << (WOF - WIF);
	end else begin : g_frac_cut
		// keep the upper fraction bits, the rest are dropped
		assign frac_out = in[WIF-1 -: WOF];
	end

	// ----------------------------------------
	// integer part
	// ----------------------------------------

	if (WOI >= WII) begin : g_int_widen
		// unsigned input, so zero extension
		assign int_out = WOI'(in[WIN-1:WIF]);
	end else begin : g_int_cut
		// high integer bits lost, no overflow detection here
		assign int_out = in[WIF+WOI-1:WIF];
	end

	assign out = {int_out, frac_out};

endmodule

// ==== verilog/div_regs_pkg.sv ====
package div_regs_pkg;

	// register data and address words
	typedef logic [15:0] reg_word_t;
	typedef logic [1:0] reg_addr_t;

	// ----------------------------------------
	// register map
	// ----------------------------------------

	localparam reg_addr_t ADDR_CTRL = 2'd0;
	localparam reg_addr_t ADDR_RESULTS = 2'd1;
	localparam reg_addr_t ADDR_OVERFLOWS = 2'd2;

	// ----------------------------------------
	// control register fields
	// ----------------------------------------

	// round to nearest, stored
	localparam int CTRL_ROUND_BIT = 0;

	// counter clear, write-only pulse, reads back as zero
	localparam int CTRL_CLEAR_BIT = 1;

endpackage

// ==== verilog/fxp_pkg.sv ====
`include "fxp_config.svh"

package fxp_pkg;

	// ----------------------------------------
	// operand and result words, two's complement
	// ----------------------------------------

	// 8.8 dividend
	typedef logic signed [`FXP_WIIA+`FXP_WIFA-1:0] dividend_t;

	// 8.8 divisor
	typedef logic signed [`FXP_WIIB+`FXP_WIFB-1:0] divisor_t;

	// 8.8 quotient, saturated
	typedef logic signed [`FXP_WOI+`FXP_WOF-1:0] quotient_t;

	// ----------------------------------------
	// internal word
	// ----------------------------------------

	// unsigned magnitudes after widening, also used for the accumulator
	typedef logic [`FXP_WRI+`FXP_WRF-1:0] work_t;

endpackage

// ==== verilog/fxp_config.svh ====
`ifndef FXP_CONFIG_SVH
`define FXP_CONFIG_SVH

// dividend format, integer and fraction bits
`define FXP_WIIA 8
`define FXP_WIFA 8

// divisor format
`define FXP_WIIB 8
`define FXP_WIFB 8

// quotient format
`define FXP_WOI 8
`define FXP_WOF 8

// working widths, large enough for the shifted divisor and the dividend
`define FXP_WRI (((`FXP_WOI + `FXP_WIIB) > `FXP_WIIA) ? (`FXP_WOI + `FXP_WIIB) : `FXP_WIIA)
`define FXP_WRF (((`FXP_WOF + `FXP_WIFB) > `FXP_WIFA) ? (`FXP_WOF + `FXP_WIFB) : `FXP_WIFA)

// sign stage + one stage per quotient bit + round + saturate
`define FXP_DIV_LATENCY (`FXP_WOI + `FXP_WOF + 3)

`define DIV_CNT_W 16

`endif
